// File: design/l1_pkg.sv
`default_nettype none

package l1_pkg;

    // Port and line sizes
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    localparam int BLOCK_W         = 128;
    localparam int WORDS_PER_BLOCK = BLOCK_W / DATA_W;

    // Organization
    localparam int WAYS  = 2;
    localparam int SETS  = 16;
    localparam int WAY_W = 1;

    // Address fields
    localparam int OFFSET_W   = 4;
    localparam int WORD_SEL_W = 2;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // One address word seen flat or split into its fields
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [TAG_W-1:0]               tag;
            logic [INDEX_W-1:0]             index;
            logic [WORD_SEL_W-1:0]          word;
            logic [OFFSET_W-WORD_SEL_W-1:0] byte_off;
        } f;
    } l1_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WB_REQ,
        FILL_REQ,
        FILL_WAIT,
        FILL_DONE
    } l1_state_e;

endpackage

`default_nettype wire

// File: design/l1_tag_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module l1_tag_data_store (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  l1_pkg::l1_addr_u            lookup_addr_i,
    input  logic [l1_pkg::WAY_W-1:0]    victim_way_i,
    input  logic                        wr_word_en_i,
    input  logic [l1_pkg::DATA_W-1:0]   wr_word_data_i,
    input  logic                        fill_en_i,
    input  logic [l1_pkg::WAY_W-1:0]    fill_way_i,
    input  logic [l1_pkg::BLOCK_W-1:0]  fill_block_i,
    input  logic                        dirty_clear_i,
    output logic                        hit_o,
    output logic [l1_pkg::WAY_W-1:0]    hit_way_o,
    output logic [l1_pkg::DATA_W-1:0]   hit_word_o,
    output logic [l1_pkg::WAYS-1:0]     set_valid_o,
    output logic                        victim_dirty_o,
    output logic [l1_pkg::TAG_W-1:0]    victim_tag_o,
    output logic [l1_pkg::BLOCK_W-1:0]  victim_block_o
);
    import l1_pkg::*;

    logic [TAG_W-1:0]   tag_q   [SETS][WAYS];
    logic [DATA_W-1:0]  data_q  [SETS][WAYS][WORDS_PER_BLOCK];
    logic [WAYS-1:0]    valid_q [SETS];
    logic [WAYS-1:0]    dirty_q [SETS];
    logic [WAYS-1:0]    way_hit;
    logic [INDEX_W-1:0] idx;

    assign idx         = lookup_addr_i.f.index;
    assign set_valid_o = valid_q[idx];

    // Tag compare across the ways of the indexed set
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup_addr_i.f.tag);
            if (way_hit[w]) begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_o      = |way_hit;
    assign hit_word_o = data_q[idx][hit_way_o][lookup_addr_i.f.word];

    assign victim_dirty_o = dirty_q[idx][victim_way_i];
    assign victim_tag_o   = tag_q[idx][victim_way_i];

    always_comb begin
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            victim_block_o[k*DATA_W +: DATA_W] = data_q[idx][victim_way_i][k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_q[idx][fill_way_i] <= lookup_addr_i.f.tag;
            for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
                data_q[idx][fill_way_i][k] <= fill_block_i[k*DATA_W +: DATA_W];
            end
        end else if (wr_word_en_i && hit_o) begin
            data_q[idx][hit_way_o][lookup_addr_i.f.word] <= wr_word_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_en_i) begin
            valid_q[idx][fill_way_i] <= 1'b1;
            dirty_q[idx][fill_way_i] <= 1'b0;
        end else if (wr_word_en_i && hit_o) begin
            dirty_q[idx][hit_way_o] <= 1'b1;
        end else if (dirty_clear_i) begin
            dirty_q[idx][victim_way_i] <= 1'b0;
        end
    end

    // A fill never installs a tag that is already present in the set
    a_one_way_hits: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// File: design/l1_victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module l1_victim_select (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic [l1_pkg::WAYS-1:0]  set_valid_i,
    input  logic                     step_i,
    output logic [l1_pkg::WAY_W-1:0] victim_way_o
);
    import l1_pkg::*;

    logic [WAY_W-1:0] evict_ctr_q;

    // Rotating eviction counter, moves on every fill
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            evict_ctr_q <= '0;
        end else if (step_i) begin
            evict_ctr_q <= (evict_ctr_q == WAY_W'(WAYS - 1)) ? '0 : evict_ctr_q + 1'b1;
        end
    end

    // Lowest invalid way wins over the counter
    always_comb begin
        victim_way_o = evict_ctr_q;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/l1_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_ctrl (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        port_req_valid_i,
    input  logic                        port_req_write_i,
    input  l1_pkg::l1_addr_u            port_req_addr_i,
    input  logic [l1_pkg::DATA_W-1:0]   port_req_data_i,
    output logic                        port_req_ready_o,
    input  logic                        port_resp_ready_i,
    output logic                        port_resp_valid_o,
    output logic [l1_pkg::DATA_W-1:0]   port_resp_data_o,
    output logic                        mem_req_valid_o,
    output logic                        mem_req_write_o,
    output logic [l1_pkg::ADDR_W-1:0]   mem_req_addr_o,
    output logic [l1_pkg::BLOCK_W-1:0]  mem_req_data_o,
    input  logic                        mem_req_ready_i,
    input  logic                        mem_rvalid_i,
    input  logic [l1_pkg::BLOCK_W-1:0]  mem_rdata_i,
    output logic                        mem_rready_o,
    output l1_pkg::l1_addr_u            lookup_addr_o,
    output logic                        wr_word_en_o,
    output logic [l1_pkg::DATA_W-1:0]   wr_word_data_o,
    output logic                        fill_en_o,
    output logic [l1_pkg::WAY_W-1:0]    fill_way_o,
    output logic [l1_pkg::BLOCK_W-1:0]  fill_block_o,
    output logic                        dirty_clear_o,
    output logic                        step_o,
    input  logic                        hit_i,
    input  logic [l1_pkg::WAY_W-1:0]    hit_way_i,
    input  logic [l1_pkg::DATA_W-1:0]   hit_word_i,
    input  logic [l1_pkg::WAY_W-1:0]    victim_way_i,
    input  logic                        victim_dirty_i,
    input  logic [l1_pkg::TAG_W-1:0]    victim_tag_i,
    input  logic [l1_pkg::BLOCK_W-1:0]  victim_block_i
);
    import l1_pkg::*;

    l1_state_e         state_q;
    l1_state_e         state_d;
    l1_addr_u          req_addr_q;
    logic              req_write_q;
    logic [DATA_W-1:0] req_data_q;
    logic [ADDR_W-1:0] fill_addr;
    logic [ADDR_W-1:0] wb_addr;
    logic              req_fire;
    logic              resp_fire;
    logic              mem_req_fire;
    logic              mem_rd_fire;

    assign req_fire     = port_req_valid_i && port_req_ready_o;
    assign resp_fire    = port_resp_valid_o && port_resp_ready_i;
    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rd_fire  = mem_rvalid_i && mem_rready_o;

    // Line-aligned addresses of the missing line and of the victim
    assign fill_addr = {req_addr_q.f.tag, req_addr_q.f.index, {OFFSET_W{1'b0}}};
    assign wb_addr   = {victim_tag_i, req_addr_q.f.index, {OFFSET_W{1'b0}}};

    assign port_req_ready_o = (state_q == IDLE);
    assign lookup_addr_o    = req_addr_q;
    assign wr_word_data_o   = req_data_q;
    assign wr_word_en_o     = (state_q == RESPOND) && req_write_q;
    assign dirty_clear_o    = (state_q == WB_REQ) && mem_req_fire;
    assign fill_en_o        = (state_q == FILL_DONE);
    assign step_o           = (state_q == FILL_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (req_fire) state_d = LOOKUP;
            LOOKUP:    state_d = hit_i ? RESPOND : (victim_dirty_i ? WB_REQ : FILL_REQ);
            RESPOND:   if (req_write_q || resp_fire) state_d = IDLE;
            WB_REQ:    if (mem_req_fire) state_d = FILL_REQ;
            FILL_REQ:  if (mem_req_fire) state_d = FILL_WAIT;
            FILL_WAIT: if (mem_rd_fire) state_d = FILL_DONE;
            FILL_DONE: state_d = LOOKUP;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q           <= IDLE;
            port_resp_valid_o <= 1'b0;
            mem_req_valid_o   <= 1'b0;
            mem_rready_o      <= 1'b0;
        end else begin
            state_q <= state_d;
            // Read data goes out one cycle into RESPOND and waits for the handshake
            if (resp_fire) begin
                port_resp_valid_o <= 1'b0;
            end else if (state_q == RESPOND && !req_write_q) begin
                port_resp_valid_o <= 1'b1;
            end
            if (state_q == LOOKUP && !hit_i) begin
                mem_req_valid_o <= 1'b1;
            end else if (state_q == FILL_REQ && mem_req_fire) begin
                mem_req_valid_o <= 1'b0;
            end
            if (state_q == FILL_REQ && mem_req_fire) begin
                mem_rready_o <= 1'b1;
            end else if (mem_rd_fire) begin
                mem_rready_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_addr_q  <= port_req_addr_i;
            req_write_q <= port_req_write_i;
            req_data_q  <= port_req_data_i;
        end
        if (state_q == RESPOND && !port_resp_valid_o) begin
            port_resp_data_o <= hit_word_i;
        end
        if (state_q == LOOKUP && !hit_i) begin
            fill_way_o      <= victim_way_i;
            mem_req_write_o <= victim_dirty_i;
            mem_req_addr_o  <= victim_dirty_i ? wb_addr : fill_addr;
            mem_req_data_o  <= victim_block_i;
        end else if (state_q == WB_REQ && mem_req_fire) begin
            mem_req_write_o <= 1'b0;
            mem_req_addr_o  <= fill_addr;
        end
        if (mem_rd_fire) begin
            fill_block_o <= mem_rdata_i;
        end
    end

    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
            && $stable({mem_req_write_o, mem_req_addr_o, mem_req_data_o}));

    // The lookup after a fill hits in the way that was just written
    a_fill_then_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_q == FILL_DONE |=> hit_i && hit_way_i == fill_way_o);

endmodule

`default_nettype wire

// File: design/l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        port_req_valid_i,
    input  logic                        port_req_write_i,
    input  l1_pkg::l1_addr_u            port_req_addr_i,
    input  logic [l1_pkg::DATA_W-1:0]   port_req_data_i,
    output logic                        port_req_ready_o,
    input  logic                        port_resp_ready_i,
    output logic                        port_resp_valid_o,
    output logic [l1_pkg::DATA_W-1:0]   port_resp_data_o,
    output logic                        mem_req_valid_o,
    output logic                        mem_req_write_o,
    output logic [l1_pkg::ADDR_W-1:0]   mem_req_addr_o,
    output logic [l1_pkg::BLOCK_W-1:0]  mem_req_data_o,
    input  logic                        mem_req_ready_i,
    input  logic                        mem_rvalid_i,
    input  logic [l1_pkg::BLOCK_W-1:0]  mem_rdata_i,
    output logic                        mem_rready_o
);
    import l1_pkg::*;

    l1_addr_u           lookup_addr;
    logic               wr_word_en;
    logic [DATA_W-1:0]  wr_word_data;
    logic               fill_en;
    logic [WAY_W-1:0]   fill_way;
    logic [BLOCK_W-1:0] fill_block;
    logic               dirty_clear;
    logic               step;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [DATA_W-1:0]  hit_word;
    logic [WAYS-1:0]    set_valid;
    logic [WAY_W-1:0]   victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [BLOCK_W-1:0] victim_block;

    l1_cache_ctrl i_l1_cache_ctrl (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .port_req_valid_i  (port_req_valid_i),
        .port_req_write_i  (port_req_write_i),
        .port_req_addr_i   (port_req_addr_i),
        .port_req_data_i   (port_req_data_i),
        .port_req_ready_o  (port_req_ready_o),
        .port_resp_ready_i (port_resp_ready_i),
        .port_resp_valid_o (port_resp_valid_o),
        .port_resp_data_o  (port_resp_data_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_write_o   (mem_req_write_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_data_o    (mem_req_data_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_rvalid_i      (mem_rvalid_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_rready_o      (mem_rready_o),
        .lookup_addr_o     (lookup_addr),
        .wr_word_en_o      (wr_word_en),
        .wr_word_data_o    (wr_word_data),
        .fill_en_o         (fill_en),
        .fill_way_o        (fill_way),
        .fill_block_o      (fill_block),
        .dirty_clear_o     (dirty_clear),
        .step_o            (step),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .hit_word_i        (hit_word),
        .victim_way_i      (victim_way),
        .victim_dirty_i    (victim_dirty),
        .victim_tag_i      (victim_tag),
        .victim_block_i    (victim_block)
    );

    l1_tag_data_store i_l1_tag_data_store (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .lookup_addr_i  (lookup_addr),
        .victim_way_i   (victim_way),
        .wr_word_en_i   (wr_word_en),
        .wr_word_data_i (wr_word_data),
        .fill_en_i      (fill_en),
        .fill_way_i     (fill_way),
        .fill_block_i   (fill_block),
        .dirty_clear_i  (dirty_clear),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .hit_word_o     (hit_word),
        .set_valid_o    (set_valid),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_block_o (victim_block)
    );

    l1_victim_select i_l1_victim_select (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .set_valid_i  (set_valid),
        .step_i       (step),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    // Reset is released on the falling edge after two rising edges
    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (2) @(negedge clk_o);
        rstn_o = 1'b1;
    end

    // 100 ns period
    always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: sim/tb_l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_dcache;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    logic         req_write;
    logic [31:0]  req_addr;
    logic [31:0]  req_data;
    logic         req_ready;
    logic         resp_ready;
    logic         resp_valid;
    logic [31:0]  resp_data;
    logic         mem_req_valid;
    logic         mem_req_write;
    logic [31:0]  mem_req_addr;
    logic [127:0] mem_req_data;
    logic         mem_req_ready;
    logic         mem_rvalid;
    logic [127:0] mem_rdata;
    logic         mem_rready;

    // Stimulus columns from the data file
    logic [7:0]   op_kind [$];
    logic [31:0]  op_addr [$];
    logic [31:0]  op_wdata [$];
    logic [31:0]  op_expect [$];
    int           op_stall [$];

    // Memory contents and the data the requester has written so far
    logic [127:0] mem_blocks [logic [31:0]];
    logic [31:0]  shadow_words [logic [31:0]];

    int           check_count = 0;
    int           error_count = 0;
    int           mem_req_count = 0;
    int           wb_count = 0;
    bit           stim_loaded = 1'b0;
    bit           have_prev = 1'b0;
    logic [31:0]  prev_line;

    tb_clk_gen i_tb_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    l1_dcache i_l1_dcache (
        .clk_i             (clk),
        .rstn_i            (rstn),
        .port_req_valid_i  (req_valid),
        .port_req_write_i  (req_write),
        .port_req_addr_i   (req_addr),
        .port_req_data_i   (req_data),
        .port_req_ready_o  (req_ready),
        .port_resp_ready_i (resp_ready),
        .port_resp_valid_o (resp_valid),
        .port_resp_data_o  (resp_data),
        .mem_req_valid_o   (mem_req_valid),
        .mem_req_write_o   (mem_req_write),
        .mem_req_addr_o    (mem_req_addr),
        .mem_req_data_o    (mem_req_data),
        .mem_req_ready_i   (mem_req_ready),
        .mem_rvalid_i      (mem_rvalid),
        .mem_rdata_i       (mem_rdata),
        .mem_rready_o      (mem_rready)
    );

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // Unwritten memory reads back as its own byte address with a fixed mask
    function automatic logic [31:0] pattern_word(input logic [31:0] byte_addr);
        return byte_addr ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [127:0] pattern_block(input logic [31:0] line_addr);
        logic [127:0] blk;
        for (int k = 0; k < 4; k++) begin
            blk[k*32 +: 32] = pattern_word(line_addr + 32'(k * 4));
        end
        return blk;
    endfunction

    // Line as the requester last wrote it
    function automatic logic [127:0] written_line(input logic [31:0] line_addr);
        logic [127:0] blk;
        logic [31:0]  a;
        for (int k = 0; k < 4; k++) begin
            a = line_addr + 32'(k * 4);
            blk[k*32 +: 32] = shadow_words.exists(a) ? shadow_words[a] : pattern_word(a);
        end
        return blk;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    fields;
        int    stall;
        string line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("sim/l1_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/l1_stim.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %d",
                                     a, d, e, stall);
                    if (fields != 4 || (line.getc(0) != "R" && line.getc(0) != "W")) begin
                        $display("Stimulus line could not be parsed: %s", line);
                        error_count++;
                    end else begin
                        op_kind.push_back(line.getc(0));
                        op_addr.push_back(a);
                        op_wdata.push_back(d);
                        op_expect.push_back(e);
                        op_stall.push_back(stall);
                    end
                end
            end
            $fclose(fd);
        end
        stim_loaded = 1'b1;
    endtask

    task automatic run_op(input int n);
        logic [31:0] line_addr;
        logic [31:0] held_data;
        int          req_before;
        int          edges;
        bit          same_line;
        bit          is_write;
        line_addr = {op_addr[n][31:4], 4'h0};
        same_line = have_prev && (line_addr == prev_line);
        is_write  = (op_kind[n] == "W");
        while (!req_ready) @(negedge clk);
        req_before = mem_req_count;
        req_valid  = 1'b1;
        req_write  = is_write;
        req_addr   = op_addr[n];
        req_data   = op_wdata[n];
        if (is_write) begin
            shadow_words[{op_addr[n][31:2], 2'b00}] = op_wdata[n];
        end
        @(negedge clk);
        req_valid = 1'b0;
        check_value(128'(req_ready), 128'(0), "ready drops after acceptance");
        edges = 0;
        if (is_write) begin
            while (!req_ready) begin
                @(negedge clk);
                edges++;
            end
        end else begin
            while (!resp_valid) begin
                @(negedge clk);
                edges++;
            end
            check_value(128'(resp_data), 128'(op_expect[n]), "read data");
            held_data = resp_data;
            // Back-pressure must freeze the response
            repeat (op_stall[n]) begin
                @(negedge clk);
                check_value(128'(resp_valid), 128'(1), "response valid under stall");
                check_value(128'(resp_data), 128'(held_data), "response data under stall");
                check_value(128'(req_ready), 128'(0), "request ready under stall");
            end
            resp_ready = 1'b1;
            @(negedge clk);
            resp_ready = 1'b0;
            check_value(128'(resp_valid), 128'(0), "response valid after handshake");
        end
        // The line was touched by the previous request, so this one must hit
        if (same_line) begin
            check_value(128'(edges), 128'(2), "hit latency in edges");
            check_value(128'(mem_req_count), 128'(req_before), "memory requests on a hit");
        end
        prev_line = line_addr;
        have_prev = 1'b1;
    endtask

    // Main memory with a random answer delay of 0 to 4 cycles
    initial begin : memory_model
        int unsigned delay;
        logic [31:0] line_addr;
        bit          is_write;
        void'($urandom(81045));
        forever begin
            @(negedge clk);
            if (rstn && mem_req_valid) begin
                delay = $urandom % 5;
                repeat (delay) @(negedge clk);
                line_addr = mem_req_addr;
                is_write  = mem_req_write;
                check_value(128'(line_addr[3:0]), 128'(0), "bus address line alignment");
                if (is_write) begin
                    check_value(mem_req_data, written_line(line_addr), "written-back block");
                    mem_blocks[line_addr] = mem_req_data;
                    wb_count++;
                end
                mem_req_ready = 1'b1;
                mem_req_count++;
                @(negedge clk);
                mem_req_ready = 1'b0;
                if (!is_write) begin
                    delay = $urandom % 5;
                    repeat (delay) @(negedge clk);
                    check_value(128'(mem_rready), 128'(1), "read ready while data is offered");
                    mem_rdata  = mem_blocks.exists(line_addr) ? mem_blocks[line_addr]
                                                              : pattern_block(line_addr);
                    mem_rvalid = 1'b1;
                    @(negedge clk);
                    mem_rvalid = 0;
                    check_value(128'(mem_rready), 128'(0), "read ready after data handshake");
                end
            end
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        repeat ((op_addr.size() + 1) * 200) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_data      = '0;
        resp_ready    = 1'b0;
        mem_req_ready = 1'b0;
        mem_rvalid    = 1'b0;
        mem_rdata     = '0;
        load_stimulus();
        wait (rstn == 1'b1);
        @(negedge clk);
        check_value(128'(req_ready), 128'(1), "request ready after reset");
        check_value(128'(resp_valid), 128'(0), "response valid after reset");
        check_value(128'(mem_req_valid), 128'(0), "memory request after reset");
        check_value(128'(mem_rready), 128'(0), "memory read ready after reset");
        for (int n = 0; n < op_addr.size(); n++) begin
            run_op(n);
        end
        if (wb_count == 0) begin
            $display("No dirty line was written back to memory");
            error_count++;
        end
        $display("Checks: %0d, errors: %0d, memory requests: %0d, write-backs: %0d",
                 check_count, error_count, mem_req_count, wb_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/l1_stim.txt
# op address  wdata    expected stall  (hex, hex, hex, decimal)
# op is R for a read or W for a write; expected is ignored for writes
R 00001010 00000000 A5A51010 0
R 00001014 00000000 A5A51014 2
W 00001018 DEADBEEF 00000000 0
R 00001018 00000000 DEADBEEF 3
R 0000101C 00000000 A5A5101C 0
R 00002010 00000000 A5A52010 0
W 00002014 12345678 00000000 0
R 00003010 00000000 A5A53010 1
R 00001018 00000000 DEADBEEF 0
R 00002014 00000000 12345678 0
R 00002010 00000000 A5A52010 0
W 000050A4 CAFEF00D 00000000 0
R 000050A4 00000000 CAFEF00D 4
R 000050A0 00000000 A5A550A0 0
W 000060A8 0BADC0DE 00000000 0
W 000070AC 55AA55AA 00000000 0
R 000060A8 00000000 0BADC0DE 0
R 000050A4 00000000 CAFEF00D 1
R 000070AC 00000000 55AA55AA 0
R 000070A0 00000000 A5A570A0 0
R FFFF00F0 00000000 5A5A00F0 2
W FFFF00FC 00000001 00000000 0
R FFFF00FC 00000000 00000001 0
R FFFF00F8 00000000 5A5A00F8 0

// File: list.f
design/l1_pkg.sv
design/l1_tag_data_store.sv
design/l1_victim_select.sv
design/l1_cache_ctrl.sv
design/l1_dcache.sv
sim/tb_clk_gen.sv
sim/tb_l1_dcache.sv

// File: run.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_l1_dcache -f list.f --Mdir obj_dir -o sim_tb_l1_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_l1_dcache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "Test passed" || exit 1
exit 0
